// ==== mips_lite.f ====
+incdir+include
source/mips_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/mips_core.sv
sim/tb_mips_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mips_core -f mips_lite.f -o tb_mips_core

out=$(./obj_dir/tb_mips_core || true)
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
   exit 0
fi
echo "simulation did not report success"
exit 1

// ==== sim/tb_mips_core.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_mips_core;

   // word address of the reset pc
   localparam logic [29:0] text_word = 30'(`MIPS_TEXT_START >> 2);
   localparam logic [31:0] halt_word = {`MIPS_OP_SPECIAL, 20'h00000, `MIPS_FN_SYSCALL};

   logic                clk = 1'b0;
   logic                rst_b = 1'b0;
   mips_pkg::word_t     inst = 32'h0000_0000;
   mips_pkg::word_t     mem_rdata;
   mips_pkg::waddr_t    inst_addr;
   mips_pkg::waddr_t    mem_addr;
   mips_pkg::word_t     mem_wdata;
   mips_pkg::byte_en_t  mem_write_en;
   logic                halted;

   // program text, data image loaded in reset, live data memory
   logic [31:0] imem [0:255];
   logic [31:0] data_image [0:255];
   logic [31:0] dmem [0:255];
   int          store_count = 0;

   // expected results and marker map
   logic [31:0] exp_words [0:63];
   int          n_exp;
   int          prog_len;
   logic        marker_present [0:15];
   logic [15:0] lfsr_state;

   mips_core dut (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst         (inst),
      .mem_rdata    (mem_rdata),
      .inst_addr    (inst_addr),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   always #2 clk = ~clk;

   // depends on every bit of the word address
   function automatic logic [31:0] fill_word(input logic [29:0] wa);
      return {wa, 2'b11} ^ 32'h5a5a_c3c3;
   endfunction

   // outside the text image the core sees a syscall
   function automatic logic [31:0] fetch_word(input logic [29:0] wa);
      logic [31:0] off;
      off = {2'b00, wa} - {2'b00, text_word};
      if (off < 32'd256) begin
         return imem[off[7:0]];
      end
      return halt_word;
   endfunction

   // instruction side, nop while in reset
   always @(negedge clk or posedge rst_b or negedge rst_b) begin
      if (!rst_b) begin
         inst <= 32'h0000_0000;
      end else begin
         inst <= fetch_word(inst_addr);
      end
   end

   // data reads answer within the cycle
   assign mem_rdata = (mem_addr < 30'd256) ? dmem[mem_addr[7:0]] : fill_word(mem_addr);

   // image reload in reset, store commit at the rising edge
   always @(posedge clk) begin
      if (!rst_b) begin
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= data_image[i];
         end
      end else if (mem_write_en != 4'b0000) begin
         if (mem_addr < 30'd256) begin
            dmem[mem_addr[7:0]] <= mem_wdata;
         end
         store_count <= store_count + 1;
      end
   end

   // 16-bit fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] val;
      val = 32'h0000_0000;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[30:0], lfsr_state[0]};
      end
      return val;
   endfunction

   function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] shamt);
      return {`MIPS_OP_SPECIAL, rs, rt, rd, shamt, funct};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] index);
      return {op, index};
   endfunction

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         stop_run($sformatf("** Error at %0t ns: %s, expected %h, got %h",
                            $time, what, expected, actual));
      end
   endtask

   // fresh text and data image for the next program
   task automatic start_program();
      for (int i = 0; i < 256; i++) begin
         imem[i] = halt_word;
         data_image[i] = fill_word(30'(i));
      end
      prog_len = 0;
      n_exp = 0;
   endtask

   task automatic emit(input logic [31:0] word);
      imem[prog_len] = word;
      prog_len = prog_len + 1;
   endtask

   task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
      emit(enc_i(`MIPS_OP_LUI, 5'd0, rd, value[31:16]));
      emit(enc_i(`MIPS_OP_ORI, rd, rd, value[15:0]));
   endtask

   // sw into the next result slot
   task automatic store_word(input logic [4:0] rt, input logic [31:0] expected);
      emit(enc_i(`MIPS_OP_SW, 5'd0, rt, 16'(n_exp * 4)));
      exp_words[n_exp] = expected;
      n_exp = n_exp + 1;
   endtask

   // result always lands in $4
   task automatic result_store(input logic [31:0] instr, input logic [31:0] expected);
      emit(instr);
      store_word(5'd4, expected);
   endtask

   task automatic check_results(input string label);
      for (int i = 0; i < n_exp; i++) begin
         check_value($sformatf("%s word %0d", label, i), exp_words[i], dmem[i]);
      end
   endtask

   task automatic reset_core();
      @(negedge clk);
      rst_b = 1'b0;
      repeat (16) begin
         @(negedge clk);
         check_value("halted in reset", 32'h0, 32'(halted));
         check_value("inst_addr in reset", 32'(text_word), 32'(inst_addr));
         check_value("write enable in reset", 32'h0, 32'(mem_write_en));
      end
      rst_b = 1'b1;
   endtask

   task automatic run_to_halt(input int limit);
      int n;
      n = 0;
      while (!halted && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         stop_run($sformatf("timeout: core did not halt within %0d cycles", limit));
      end
   endtask

   task automatic wait_for_fetch(input logic [29:0] target, input int limit);
      int n;
      n = 0;
      while (inst_addr != target && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (inst_addr != target) begin
         stop_run("timeout: the halting instruction was never fetched");
      end
   endtask

   task automatic test_alu();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] tmp;
      logic [15:0] imm;
      logic [31:0] imm_s;
      logic [4:0]  sh;
      a = random_bits(32);
      b = random_bits(32);
      c = random_bits(32);
      tmp = random_bits(16);
      imm = tmp[15:0];
      imm_s = {{16{imm[15]}}, imm};
      tmp = random_bits(5);
      sh = tmp[4:0];
      start_program();
      // $1 = a, $2 = b, $3 = shift source
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      load_reg(5'd3, c);
      result_store(enc_r(`MIPS_FN_ADDU, 5'd1, 5'd2, 5'd4, 5'd0), a + b);
      result_store(enc_r(`MIPS_FN_SUBU, 5'd1, 5'd2, 5'd4, 5'd0), a - b);
      result_store(enc_r(`MIPS_FN_AND, 5'd1, 5'd2, 5'd4, 5'd0), a & b);
      result_store(enc_r(`MIPS_FN_OR, 5'd1, 5'd2, 5'd4, 5'd0), a | b);
      result_store(enc_r(`MIPS_FN_XOR, 5'd1, 5'd2, 5'd4, 5'd0), a ^ b);
      result_store(enc_r(`MIPS_FN_NOR, 5'd1, 5'd2, 5'd4, 5'd0), ~(a | b));
      // signed compare both ways
      result_store(enc_r(`MIPS_FN_SLT, 5'd1, 5'd2, 5'd4, 5'd0),
                   ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      result_store(enc_r(`MIPS_FN_SLT, 5'd2, 5'd1, 5'd4, 5'd0),
                   ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
      result_store(enc_r(`MIPS_FN_SLL, 5'd0, 5'd2, 5'd4, sh), b << sh);
      result_store(enc_r(`MIPS_FN_SRL, 5'd0, 5'd2, 5'd4, sh), b >> sh);
      result_store(enc_r(`MIPS_FN_SRA, 5'd0, 5'd2, 5'd4, sh), $signed(b) >>> sh);
      // amount from the low five bits of rs
      result_store(enc_r(`MIPS_FN_SLLV, 5'd3, 5'd2, 5'd4, 5'd0), b << c[4:0]);
      result_store(enc_r(`MIPS_FN_SRLV, 5'd3, 5'd2, 5'd4, 5'd0), b >> c[4:0]);
      result_store(enc_r(`MIPS_FN_SRAV, 5'd3, 5'd2, 5'd4, 5'd0), $signed(b) >>> c[4:0]);
      result_store(enc_i(`MIPS_OP_ADDIU, 5'd1, 5'd4, imm), a + imm_s);
      // logical immediates zero extend
      result_store(enc_i(`MIPS_OP_ANDI, 5'd1, 5'd4, imm), a & {16'h0000, imm});
      result_store(enc_i(`MIPS_OP_ORI, 5'd1, 5'd4, imm), a | {16'h0000, imm});
      result_store(enc_i(`MIPS_OP_XORI, 5'd1, 5'd4, imm), a ^ {16'h0000, imm});
      result_store(enc_i(`MIPS_OP_SLTI, 5'd1, 5'd4, imm),
                   ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0);
      result_store(enc_i(`MIPS_OP_LUI, 5'd0, 5'd4, imm), {imm, 16'h0000});
      // write to $0 is lost
      emit(enc_r(`MIPS_FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
      store_word(5'd0, 32'h0000_0000);
      emit(halt_word);
      reset_core();
      run_to_halt(500);
      check_results("alu");
   endtask

   task automatic test_loads();
      logic [31:0] base;
      logic [31:0] w;
      logic [15:0] addr;
      base = random_bits(32);
      start_program();
      for (int k = 0; k < 2; k++) begin
         // first word negative halfword and byte, second positive
         w = (k == 0) ? (base | 32'h0000_8080) : (base & 32'hffff_7f7f);
         data_image[100 + k] = w;
         addr = 16'(400 + 4 * k);
         emit(enc_i(`MIPS_OP_LW, 5'd0, 5'd5, addr));
         store_word(5'd5, w);
         emit(enc_i(`MIPS_OP_LH, 5'd0, 5'd5, addr));
         store_word(5'd5, {{16{w[15]}}, w[15:0]});
         emit(enc_i(`MIPS_OP_LHU, 5'd0, 5'd5, addr));
         store_word(5'd5, {16'h0000, w[15:0]});
         emit(enc_i(`MIPS_OP_LB, 5'd0, 5'd5, addr));
         store_word(5'd5, {{24{w[7]}}, w[7:0]});
         emit(enc_i(`MIPS_OP_LBU, 5'd0, 5'd5, addr));
         store_word(5'd5, {24'h00_0000, w[7:0]});
      end
      emit(halt_word);
      reset_core();
      run_to_halt(500);
      check_results("load");
   endtask

   // two words, marker value into a fixed slot
   task automatic emit_marker(input int slot, input logic present);
      emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd10, 16'(32'h0a00 + slot)));
      emit(enc_i(`MIPS_OP_SW, 5'd0, 5'd10, 16'(slot * 4)));
      marker_present[slot] = present;
   endtask

   task automatic test_control_flow();
      logic [31:0] r;
      logic [31:0] target;
      logic [31:0] expected;
      r = random_bits(32);
      start_program();
      // $1 == $2, $3 differs
      load_reg(5'd1, r);
      load_reg(5'd2, r);
      load_reg(5'd3, r ^ 32'h0000_0001);
      // offset 2 skips exactly one marker
      emit(enc_i(`MIPS_OP_BEQ, 5'd1, 5'd2, 16'd2));
      emit_marker(0, 1'b0);
      emit_marker(1, 1'b1);
      emit(enc_i(`MIPS_OP_BEQ, 5'd1, 5'd3, 16'd2));
      emit_marker(2, 1'b1);
      emit_marker(3, 1'b1);
      emit(enc_i(`MIPS_OP_BNE, 5'd1, 5'd3, 16'd2));
      emit_marker(4, 1'b0);
      emit_marker(5, 1'b1);
      emit(enc_i(`MIPS_OP_BNE, 5'd1, 5'd2, 16'd2));
      emit_marker(6, 1'b1);
      emit_marker(7, 1'b1);
      // j lands three words on
      emit(enc_j(`MIPS_OP_J, 26'(32'(text_word) + 32'(prog_len) + 32'd3)));
      emit_marker(8, 1'b0);
      emit_marker(9, 1'b1);
      // jr through $11, past lui ori jr and one marker
      target = `MIPS_TEXT_START + 32'(4 * (prog_len + 5));
      emit(enc_i(`MIPS_OP_LUI, 5'd0, 5'd11, target[31:16]));
      emit(enc_i(`MIPS_OP_ORI, 5'd11, 5'd11, target[15:0]));
      emit(enc_r(`MIPS_FN_JR, 5'd11, 5'd0, 5'd0, 5'd0));
      emit_marker(10, 1'b0);
      emit_marker(11, 1'b1);
      emit(halt_word);
      reset_core();
      run_to_halt(500);
      for (int s = 0; s < 12; s++) begin
         expected = marker_present[s] ? 32'(32'h0a00 + s) : fill_word(30'(s));
         check_value($sformatf("marker slot %0d", s), expected, dmem[s]);
      end
   endtask

   task automatic test_halt(input logic [31:0] stop_word, input string label);
      logic [29:0] stop_addr;
      int          count_at_halt;
      start_program();
      emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd1, 16'h0055));
      emit(enc_i(`MIPS_OP_SW, 5'd0, 5'd1, 16'd0));
      emit(stop_word);
      // never reached
      emit(enc_i(`MIPS_OP_SW, 5'd0, 5'd1, 16'd4));
      emit(enc_i(`MIPS_OP_SW, 5'd0, 5'd1, 16'd8));
      stop_addr = text_word + 30'd2;
      reset_core();
      wait_for_fetch(stop_addr, 100);
      check_value({label, " halted while fetched"}, 32'h0, 32'(halted));
      @(negedge clk);
      check_value({label, " halted after the edge"}, 32'h1, 32'(halted));
      count_at_halt = store_count;
      // pc frozen on the halting word
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         check_value({label, " frozen inst_addr"}, 32'(stop_addr), 32'(inst_addr));
      end
      check_value({label, " stores after halt"}, 32'(count_at_halt), 32'(store_count));
      check_value({label, " store before halt"}, 32'h0000_0055, dmem[0]);
      check_value({label, " word 1 untouched"}, fill_word(30'd1), dmem[1]);
      check_value({label, " word 2 untouched"}, fill_word(30'd2), dmem[2]);
   endtask

   initial begin
      logic [31:0] tmp;
      lfsr_state = 16'd48;
      test_alu();
      test_loads();
      test_control_flow();
      test_halt(halt_word, "syscall");
      // opcode 0x3f is not decoded
      tmp = random_bits(26);
      test_halt({6'h3f, tmp[25:0]}, "undecoded");
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== source/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::word_t    inst,
   input  mips_pkg::word_t    mem_rdata,
   output mips_pkg::waddr_t   inst_addr,
   output mips_pkg::waddr_t   mem_addr,
   output mips_pkg::word_t    mem_wdata,
   output mips_pkg::byte_en_t mem_write_en,
   output logic               halted
);

   // fetch
   mips_pkg::word_t     pc_plus4;

   // decode
   mips_pkg::reg_idx_t  rs;
   mips_pkg::reg_idx_t  rt;
   mips_pkg::reg_idx_t  wr_reg;
   mips_pkg::word_t     imm_ext;
   mips_pkg::imm16_t    imm;
   logic [25:0]         jump_index;
   mips_pkg::alu_sel_t  alu_sel;
   logic                alu_src_imm;
   logic                shift_var;
   mips_pkg::load_sel_t load_sel;
   mips_pkg::wb_sel_t   wb_sel;
   logic                reg_we;
   logic                branch_eq;
   logic                branch_ne;
   logic                jump;
   logic                jump_reg;
   logic                halt_req;

   // register read, execute and write-back
   mips_pkg::word_t     rs_data;
   mips_pkg::word_t     rt_data;
   mips_pkg::word_t     alu_out;
   logic                branch_taken;
   mips_pkg::word_t     branch_target;
   mips_pkg::word_t     jump_target;
   mips_pkg::word_t     wr_data;

   fetch_stage u_fetch (
      .clk           (clk),
      .rst_b         (rst_b),
      .halt_req      (halt_req),
      .branch_taken  (branch_taken),
      .jump          (jump),
      .jump_reg      (jump_reg),
      .branch_target (branch_target),
      .jump_target   (jump_target),
      .rs_data       (rs_data),
      .pc            (),
      .pc_plus4      (pc_plus4),
      .inst_addr     (inst_addr),
      .halted        (halted)
   );

   // halted gates the writes in here
   decode_stage u_decode (
      .inst          (inst),
      .halted        (halted),
      .rs            (rs),
      .rt            (rt),
      .wr_reg        (wr_reg),
      .imm_ext       (imm_ext),
      .imm           (imm),
      .jump_index    (jump_index),
      .alu_sel       (alu_sel),
      .alu_src_imm   (alu_src_imm),
      .shift_var     (shift_var),
      .load_sel      (load_sel),
      .wb_sel        (wb_sel),
      .reg_we        (reg_we),
      .mem_write_en  (mem_write_en),
      .branch_eq     (branch_eq),
      .branch_ne     (branch_ne),
      .jump          (jump),
      .jump_reg      (jump_reg),
      .halt_req      (halt_req)
   );

   reg_file u_reg_file (
      .clk           (clk),
      .rst_b         (rst_b),
      .rs            (rs),
      .rt            (rt),
      .wr_reg        (wr_reg),
      .wr_data       (wr_data),
      .we            (reg_we),
      .rs_data       (rs_data),
      .rt_data       (rt_data)
   );

   execute_stage u_execute (
      .rs_data       (rs_data),
      .rt_data       (rt_data),
      .imm_ext       (imm_ext),
      .pc_plus4      (pc_plus4),
      .alu_sel       (alu_sel),
      .alu_src_imm   (alu_src_imm),
      .shift_var     (shift_var),
      .branch_eq     (branch_eq),
      .branch_ne     (branch_ne),
      .jump_index    (jump_index),
      .alu_out       (alu_out),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .jump_target   (jump_target)
   );

   // data memory answers in the same cycle
   mem_wb_stage u_mem_wb (
      .alu_out       (alu_out),
      .rt_data       (rt_data),
      .mem_rdata     (mem_rdata),
      .imm           (imm),
      .load_sel      (load_sel),
      .wb_sel        (wb_sel),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .wr_data       (wr_data)
   );

endmodule

// ==== source/mem_wb_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module mem_wb_stage (
   input  mips_pkg::word_t     alu_out,
   input  mips_pkg::word_t     rt_data,
   input  mips_pkg::word_t     mem_rdata,
   input  mips_pkg::imm16_t    imm,
   input  mips_pkg::load_sel_t load_sel,
   input  mips_pkg::wb_sel_t   wb_sel,
   output mips_pkg::waddr_t    mem_addr,
   output mips_pkg::word_t     mem_wdata,
   output mips_pkg::word_t     wr_data
);

   mips_pkg::word_t load_data;

   // byte offset dropped, word addressed memory
   assign mem_addr  = alu_out[31:2];
   assign mem_wdata = rt_data;

   // sub-word loads use the low lanes only
   always_comb begin
      case (load_sel)
         `MIPS_LOAD_LW:  load_data = mem_rdata;
         `MIPS_LOAD_LH:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
         `MIPS_LOAD_LHU: load_data = {16'h0000, mem_rdata[15:0]};
         `MIPS_LOAD_LB:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
         `MIPS_LOAD_LBU: load_data = {24'h00_0000, mem_rdata[7:0]};
         // upper half from imm, lower half zero
         `MIPS_LOAD_LUI: load_data = {imm, 16'h0000};
         default:        load_data = mem_rdata;
      endcase
   end

   // write-back mux
   assign wr_data = (wb_sel == `MIPS_WB_LOAD) ? load_data : alu_out;

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module execute_stage (
   input  mips_pkg::word_t    rs_data,
   input  mips_pkg::word_t    rt_data,
   input  mips_pkg::word_t    imm_ext,
   input  mips_pkg::word_t    pc_plus4,
   input  mips_pkg::alu_sel_t alu_sel,
   input  logic               alu_src_imm,
   input  logic               shift_var,
   input  logic               branch_eq,
   input  logic               branch_ne,
   input  logic [25:0]        jump_index,
   output mips_pkg::word_t    alu_out,
   output logic               branch_taken,
   output mips_pkg::word_t    branch_target,
   output mips_pkg::word_t    jump_target
);

   mips_pkg::word_t op_b;
   logic [4:0]      shamt;
   logic            rs_eq_rt;

   // second operand, rt or extended immediate
   assign op_b = alu_src_imm ? imm_ext : rt_data;

   // shamt field for fixed shifts, rs low bits otherwise
   assign shamt = shift_var ? rs_data[4:0] : imm_ext[10:6];

   always_comb begin
      case (alu_sel)
         `MIPS_ALU_ADD: alu_out = rs_data + op_b;
         `MIPS_ALU_SUB: alu_out = rs_data - op_b;
         // shifts always act on rt
         `MIPS_ALU_SLL, `MIPS_ALU_SLLV: alu_out = rt_data << shamt;
         `MIPS_ALU_SRL, `MIPS_ALU_SRLV: alu_out = rt_data >> shamt;
         `MIPS_ALU_SRA, `MIPS_ALU_SRAV: alu_out = $signed(rt_data) >>> shamt;
         `MIPS_ALU_AND: alu_out = rs_data & op_b;
         `MIPS_ALU_OR:  alu_out = rs_data | op_b;
         `MIPS_ALU_XOR: alu_out = rs_data ^ op_b;
         `MIPS_ALU_NOR: alu_out = ~(rs_data | op_b);
         // signed compare for slt and slti
         `MIPS_ALU_SLT: alu_out = ($signed(rs_data) < $signed(op_b)) ? 32'd1 : 32'd0;
         default:       alu_out = 32'h0000_0000;
      endcase
   end

   // beq / bne compare
   assign rs_eq_rt     = (rs_data == rt_data);
   assign branch_taken = (branch_eq & rs_eq_rt) | (branch_ne & ~rs_eq_rt);

   // word offset relative to pc+4
   assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};

   // region bits from pc+4
   assign jump_target = {pc_plus4[31:28], jump_index, 2'b00};

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module reg_file (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs,
   input  mips_pkg::reg_idx_t rt,
   input  mips_pkg::reg_idx_t wr_reg,
   input  mips_pkg::word_t    wr_data,
   input  logic               we,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data
);

   // $0 has no storage
   mips_pkg::word_t regs [1:`MIPS_REG_COUNT-1];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < `MIPS_REG_COUNT; i++) begin
            regs[i] <= 32'h0000_0000;
         end
      end else if (we && (wr_reg != 5'd0)) begin
         // writes to $0 are dropped
         regs[wr_reg] <= wr_data;
      end
   end

   // combinational reads, new value seen next cycle
   assign rs_data = (rs == 5'd0) ? 32'h0000_0000 : regs[rs];
   assign rt_data = (rt == 5'd0) ? 32'h0000_0000 : regs[rt];

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module decode_stage (
   input  mips_pkg::word_t     inst,
   input  logic                halted,
   output mips_pkg::reg_idx_t  rs,
   output mips_pkg::reg_idx_t  rt,
   output mips_pkg::reg_idx_t  wr_reg,
   output mips_pkg::word_t     imm_ext,
   output mips_pkg::imm16_t    imm,
   output logic [25:0]         jump_index,
   output mips_pkg::alu_sel_t  alu_sel,
   output logic                alu_src_imm,
   output logic                shift_var,
   output mips_pkg::load_sel_t load_sel,
   output mips_pkg::wb_sel_t   wb_sel,
   output logic                reg_we,
   output mips_pkg::byte_en_t  mem_write_en,
   output logic                branch_eq,
   output logic                branch_ne,
   output logic                jump,
   output logic                jump_reg,
   output logic                halt_req
);

   logic [5:0]         opcode;
   logic [5:0]         funct;
   logic               sign_ext;
   logic               dst_rd;
   logic               we_raw;
   mips_pkg::byte_en_t store_en;

   // instruction fields
   assign opcode     = inst[31:26];
   assign funct      = inst[5:0];
   assign rs         = inst[25:21];
   assign rt         = inst[20:16];
   assign imm        = inst[15:0];
   assign jump_index = inst[25:0];

   // shamt bits survive either extension
   assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

   // R-type writes rd, everything else writes rt
   assign wr_reg = dst_rd ? inst[15:11] : inst[20:16];

   // no architectural update once halted
   assign reg_we       = we_raw & ~halted;
   assign mem_write_en = halted ? 4'b0000 : store_en;

   always_comb begin
      // unknown encodings fall through as a halt
      alu_sel     = `MIPS_ALU_ADD;
      alu_src_imm = 1'b0;
      shift_var   = 1'b0;
      load_sel    = `MIPS_LOAD_LW;
      wb_sel      = `MIPS_WB_ALU;
      sign_ext    = 1'b1;
      dst_rd      = 1'b0;
      we_raw      = 1'b0;
      store_en    = 4'b0000;
      branch_eq   = 1'b0;
      branch_ne   = 1'b0;
      jump        = 1'b0;
      jump_reg    = 1'b0;
      halt_req    = 1'b1;
      case (opcode)
         `MIPS_OP_SPECIAL: begin
            dst_rd   = 1'b1;
            we_raw   = 1'b1;
            halt_req = 1'b0;
            case (funct)
               `MIPS_FN_ADDU: alu_sel = `MIPS_ALU_ADD;
               `MIPS_FN_SUBU: alu_sel = `MIPS_ALU_SUB;
               `MIPS_FN_AND:  alu_sel = `MIPS_ALU_AND;
               `MIPS_FN_OR:   alu_sel = `MIPS_ALU_OR;
               `MIPS_FN_XOR:  alu_sel = `MIPS_ALU_XOR;
               `MIPS_FN_NOR:  alu_sel = `MIPS_ALU_NOR;
               `MIPS_FN_SLT:  alu_sel = `MIPS_ALU_SLT;
               `MIPS_FN_SLL:  alu_sel = `MIPS_ALU_SLL;
               `MIPS_FN_SRL:  alu_sel = `MIPS_ALU_SRL;
               `MIPS_FN_SRA:  alu_sel = `MIPS_ALU_SRA;
               // variable shifts take the amount from rs
               `MIPS_FN_SLLV: begin
                  alu_sel   = `MIPS_ALU_SLLV;
                  shift_var = 1'b1;
               end
               `MIPS_FN_SRLV: begin
                  alu_sel   = `MIPS_ALU_SRLV;
                  shift_var = 1'b1;
               end
               `MIPS_FN_SRAV: begin
                  alu_sel   = `MIPS_ALU_SRAV;
                  shift_var = 1'b1;
               end
               `MIPS_FN_JR: begin
                  we_raw   = 1'b0;
                  jump_reg = 1'b1;
               end
               default: begin
                  // syscall and unknown funct both stop the core
                  we_raw   = 1'b0;
                  halt_req = 1'b1;
               end
            endcase
         end
         `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI: begin
            alu_src_imm = 1'b1;
            we_raw      = 1'b1;
            halt_req    = 1'b0;
            case (opcode)
               `MIPS_OP_SLTI: alu_sel = `MIPS_ALU_SLT;
               `MIPS_OP_ANDI: alu_sel = `MIPS_ALU_AND;
               `MIPS_OP_ORI:  alu_sel = `MIPS_ALU_OR;
               `MIPS_OP_XORI: alu_sel = `MIPS_ALU_XOR;
               default:       alu_sel = `MIPS_ALU_ADD;
            endcase
            // logical immediates are zero extended
            sign_ext = (opcode == `MIPS_OP_ADDIU) || (opcode == `MIPS_OP_SLTI);
         end
         `MIPS_OP_LUI: begin
            // lui rides the load path, built from imm
            load_sel = `MIPS_LOAD_LUI;
            wb_sel   = `MIPS_WB_LOAD;
            we_raw   = 1'b1;
            halt_req = 1'b0;
         end
         `MIPS_OP_LW, `MIPS_OP_LH, `MIPS_OP_LHU, `MIPS_OP_LB, `MIPS_OP_LBU: begin
            alu_src_imm = 1'b1;
            wb_sel      = `MIPS_WB_LOAD;
            we_raw      = 1'b1;
            halt_req    = 1'b0;
            case (opcode)
               `MIPS_OP_LH:  load_sel = `MIPS_LOAD_LH;
               `MIPS_OP_LHU: load_sel = `MIPS_LOAD_LHU;
               `MIPS_OP_LB:  load_sel = `MIPS_LOAD_LB;
               `MIPS_OP_LBU: load_sel = `MIPS_LOAD_LBU;
               default:      load_sel = `MIPS_LOAD_LW;
            endcase
         end
         `MIPS_OP_SW: begin
            // word stores only, all lanes
            alu_src_imm = 1'b1;
            store_en    = 4'b1111;
            halt_req    = 1'b0;
         end
         `MIPS_OP_BEQ: begin
            branch_eq = 1'b1;
            halt_req  = 1'b0;
         end
         `MIPS_OP_BNE: begin
            branch_ne = 1'b1;
            halt_req  = 1'b0;
         end
         `MIPS_OP_J: begin
            jump     = 1'b1;
            halt_req = 1'b0;
         end
         default: begin
            halt_req = 1'b1;
         end
      endcase
   end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module fetch_stage (
   input  logic             clk,
   input  logic             rst_b,
   input  logic             halt_req,
   input  logic             branch_taken,
   input  logic             jump,
   input  logic             jump_reg,
   input  mips_pkg::word_t  branch_target,
   input  mips_pkg::word_t  jump_target,
   input  mips_pkg::word_t  rs_data,
   output mips_pkg::word_t  pc,
   output mips_pkg::word_t  pc_plus4,
   output mips_pkg::waddr_t inst_addr,
   output logic             halted
);

   mips_pkg::word_t next_pc;

   assign pc_plus4 = pc + 32'd4;

   // memory is word addressed
   assign inst_addr = pc[31:2];

   // next pc priority, jr first, then j, then branch
   // no delay slot, so the redirect lands directly
   always_comb begin
      if (jump_reg) begin
         next_pc = rs_data;
      end else if (jump) begin
         next_pc = jump_target;
      end else if (branch_taken) begin
         next_pc = branch_target;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= `MIPS_TEXT_START;
         halted <= 1'b0;
      end else begin
         // pc stays on the halting instruction
         if (!halted && !halt_req) begin
            pc <= next_pc;
         end
         // sticky until the next reset
         if (halt_req) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

// ==== source/mips_pkg.sv ====
package mips_pkg;

   // data word or byte address
   typedef logic [31:0] word_t;

   // word address, byte address without the low two bits
   typedef logic [29:0] waddr_t;

   // register number
   typedef logic [4:0]  reg_idx_t;

   // raw immediate field of the instruction
   typedef logic [15:0] imm16_t;

   // alu operation select
   typedef logic [3:0]  alu_sel_t;

   // load extraction select, lui included
   typedef logic [2:0]  load_sel_t;

   // write-back source, alu or load path
   typedef logic        wb_sel_t;

   // one enable per byte lane of the data write
   typedef logic [3:0]  byte_en_t;

endpackage

// ==== include/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// reset pc, start of the text segment
`define MIPS_TEXT_START 32'h00400000
`define MIPS_REG_COUNT  32

// primary opcodes
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_J       6'h02
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_SLTI    6'h0a
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LB      6'h20
`define MIPS_OP_LH      6'h21
`define MIPS_OP_LW      6'h23
`define MIPS_OP_LBU     6'h24
`define MIPS_OP_LHU     6'h25
`define MIPS_OP_SW      6'h2b

// funct codes under SPECIAL
`define MIPS_FN_SLL     6'h00
`define MIPS_FN_SRL     6'h02
`define MIPS_FN_SRA     6'h03
`define MIPS_FN_SLLV    6'h04
`define MIPS_FN_SRLV    6'h06
`define MIPS_FN_SRAV    6'h07
`define MIPS_FN_JR      6'h08
`define MIPS_FN_SYSCALL 6'h0c
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_NOR     6'h27
`define MIPS_FN_SLT     6'h2a

// alu selects
`define MIPS_ALU_ADD    4'h0
`define MIPS_ALU_SUB    4'h1
`define MIPS_ALU_SLL    4'h2
`define MIPS_ALU_SRL    4'h3
`define MIPS_ALU_SRA    4'h4
`define MIPS_ALU_SLLV   4'h5
`define MIPS_ALU_SRLV   4'h6
`define MIPS_ALU_SRAV   4'h7
`define MIPS_ALU_AND    4'h8
`define MIPS_ALU_OR     4'h9
`define MIPS_ALU_XOR    4'ha
`define MIPS_ALU_NOR    4'hb
`define MIPS_ALU_SLT    4'hc

// load extraction selects
`define MIPS_LOAD_LW    3'h0
`define MIPS_LOAD_LH    3'h1
`define MIPS_LOAD_LHU   3'h2
`define MIPS_LOAD_LB    3'h3
`define MIPS_LOAD_LBU   3'h4
`define MIPS_LOAD_LUI   3'h5

// write-back source
`define MIPS_WB_ALU     1'b0
`define MIPS_WB_LOAD    1'b1

`endif
